/* common/cache_pkg.sv */
package cache_pkg;

    // the processor gives word addresses of this width.
    localparam int addr_bits = 32;

    localparam int cache_bytes = 8192;
    localparam int line_bits = 128;
    localparam int word_bits = 32;

    localparam int num_lines = cache_bytes * 8 / line_bits;
    localparam int words_per_line = line_bits / word_bits;

    // an address splits into tag, index and word offset, from high bits to low.
    localparam int index_bits = $clog2(num_lines);
    localparam int offset_bits = $clog2(words_per_line);
    localparam int tag_bits = addr_bits - index_bits - offset_bits;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

    localparam int mem_addr_bits = 32;
    localparam int mem_line_bits = 128;
    localparam int mem_word_bits = 32;

    // memory serves whole lines, so a line address has this many low bits at zero.
    localparam int mem_align_bits = $clog2(mem_line_bits / mem_word_bits);

endpackage

/* hw/addr_parser.sv */
module addr_parser import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   read_en,
    input  logic                   busy,
    input  logic [addr_bits-1:0]   addr,
    output logic [tag_bits-1:0]    tag,
    output logic [index_bits-1:0]  index,
    output logic [offset_bits-1:0] offset,
    output logic                   lookup
);

    logic accept;

    // a strobe that arrives while a miss is pending is dropped here.
    assign accept = read_en && !busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup <= 1'b0;
        end else begin
            lookup <= accept;
        end
    end

    // the fields hold until the next accepted request, which keeps them
    // stable for the fill and the memory address during a miss.
    always_ff @(posedge clk) begin
        if (accept) begin
            tag    <= addr[addr_bits-1 -: tag_bits];
            index  <= addr[offset_bits +: index_bits];
            offset <= addr[offset_bits-1:0];
        end
    end

endmodule

/* cache_core/line_store.sv */
module line_store import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [index_bits-1:0] index,
    input  logic [tag_bits-1:0]   tag,
    input  logic                  fill_en,
    input  logic [line_bits-1:0]  fill_line,
    output logic [line_bits-1:0]  line,
    output logic                  tag_match
);

    logic [tag_bits-1:0]  tag_mem [num_lines];
    logic [line_bits-1:0] data_mem [num_lines];
    logic [num_lines-1:0] valid;

    logic [tag_bits-1:0]  stored_tag;
    logic                 stored_valid;

    // only the valid bits start from a known state.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= fill_line;
        end
    end

    // reads are asynchronous off the registered index from the address parser.
    assign stored_tag   = tag_mem[index];
    assign stored_valid = valid[index];
    assign line         = data_mem[index];

    assign tag_match = stored_valid && (stored_tag == tag);

endmodule

/* cache_core/miss_controller.sv */
module miss_controller import cache_pkg::*, mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lookup,
    input  logic                     tag_match,
    input  logic [tag_bits-1:0]      tag,
    input  logic [index_bits-1:0]    index,
    input  logic                     mem_ready,
    output logic                     busy,
    output logic                     mem_req,
    output logic [mem_addr_bits-1:0] mem_addr,
    output logic                     fill_en,
    output logic                     resp_en,
    output logic                     resp_hit
);

    typedef enum logic {
        st_idle,
        st_wait_mem
    } state_t;

    state_t state;
    logic   miss_now;
    logic   busy_q;
    logic   fill_done;

    assign miss_now = lookup && !tag_match && (state == st_idle);

    // the line is taken in the same cycle that memory presents it.
    assign fill_en = (state == st_wait_mem) && mem_req && mem_ready;

    // a hit answers from the lookup cycle, a miss from the fill cycle.
    assign resp_en  = (lookup && tag_match) || fill_en;
    assign resp_hit = lookup && tag_match;

    // the lookup cycle of a miss already blocks the next strobe, so a second
    // request never lands on top of the pending one.
    assign busy = busy_q || miss_now;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= st_idle;
            busy_q    <= 1'b0;
            fill_done <= 1'b0;
            mem_req   <= 1'b0;
        end else begin
            fill_done <= fill_en;
            case (state)
                st_idle: begin
                    if (miss_now) begin
                        state  <= st_wait_mem;
                        busy_q <= 1'b1;
                    end else if (fill_done) begin
                        busy_q <= 1'b0;
                    end
                end
                st_wait_mem: begin
                    if (fill_en) begin
                        state   <= st_idle;
                        mem_req <= 1'b0;
                    end else begin
                        mem_req <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // busy drops one cycle after the fill, together with rdata_valid.
    // the address is taken when the miss is found and held while waiting.
    always_ff @(posedge clk) begin
        if (miss_now) begin
            mem_addr <= {tag, index, {mem_align_bits{1'b0}}};
        end
    end

endmodule

/* hw/word_select.sv */
module word_select import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [offset_bits-1:0] offset,
    input  logic                   resp_en,
    input  logic                   resp_hit,
    input  logic [line_bits-1:0]   cache_line,
    input  logic [line_bits-1:0]   mem_line,
    output logic [word_bits-1:0]   data_out,
    output logic                   hit,
    output logic                   rdata_valid
);

    logic [line_bits-1:0] src_line;
    logic [word_bits-1:0] word;
    logic                 sel_valid;
    logic                 sel_hit;
    logic [word_bits-1:0] sel_word;

    assign src_line = resp_hit ? cache_line : mem_line;
    assign word     = src_line[offset*word_bits +: word_bits];

    // first stage catches the word while the line store still shows this
    // request, so the next hit may already be in the address parser.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sel_valid <= 1'b0;
            sel_hit   <= 1'b0;
        end else begin
            sel_valid <= resp_en;
            sel_hit   <= resp_en && resp_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_en) begin
            sel_word <= word;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_out    <= '0;
            hit         <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= sel_valid;
            if (sel_valid) begin
                data_out <= sel_word;
                hit      <= sel_hit;
            end
        end
    end

endmodule

/* hw/cache_top.sv */
module cache_top import cache_pkg::*, mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     read_en,
    input  logic [addr_bits-1:0]     addr,
    output logic [word_bits-1:0]     data_out,
    output logic                     hit,
    output logic                     rdata_valid,
    output logic                     busy,
    output logic [mem_addr_bits-1:0] mem_addr,
    output logic                     mem_req,
    input  logic [mem_line_bits-1:0] mem_data_in,
    input  logic                     mem_ready
);

    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [offset_bits-1:0] offset;
    logic                   lookup;
    logic [line_bits-1:0]   line;
    logic                   tag_match;
    logic                   fill_en;
    logic                   resp_en;
    logic                   resp_hit;

    addr_parser u_addr_parser (
        .clk     (clk),
        .rst     (rst),
        .read_en (read_en),
        .busy    (busy),
        .addr    (addr),
        .tag     (tag),
        .index   (index),
        .offset  (offset),
        .lookup  (lookup)
    );

    // the fill line comes straight from memory in the cycle of mem_ready.
    line_store u_line_store (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .tag       (tag),
        .fill_en   (fill_en),
        .fill_line (mem_data_in),
        .line      (line),
        .tag_match (tag_match)
    );

    miss_controller u_miss_controller (
        .clk       (clk),
        .rst       (rst),
        .lookup    (lookup),
        .tag_match (tag_match),
        .tag       (tag),
        .index     (index),
        .mem_ready (mem_ready),
        .busy      (busy),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .fill_en   (fill_en),
        .resp_en   (resp_en),
        .resp_hit  (resp_hit)
    );

    word_select u_word_select (
        .clk         (clk),
        .rst         (rst),
        .offset      (offset),
        .resp_en     (resp_en),
        .resp_hit    (resp_hit),
        .cache_line  (line),
        .mem_line    (mem_data_in),
        .data_out    (data_out),
        .hit         (hit),
        .rdata_valid (rdata_valid)
    );

endmodule

/* verification/clk_gen.sv */
module clk_gen #(
    parameter int period = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // reset is released on a falling edge, half a period away from the flops.
    initial begin
        rst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

/* verification/cache_tb.sv */
module cache_tb import cache_pkg::*, mem_pkg::*; ();

    localparam int clk_period = 20;
    localparam int rand_len = 64;
    localparam int resp_timeout = 40;
    localparam int rand_seed = 77506;
    localparam logic [word_bits-1:0] model_key = 32'h5A3C_96E1;

    logic                     clk;
    logic                     rst;
    logic                     read_en;
    logic [addr_bits-1:0]     addr;
    logic [word_bits-1:0]     data_out;
    logic                     hit;
    logic                     rdata_valid;
    logic                     busy;
    logic [mem_addr_bits-1:0] mem_addr;
    logic                     mem_req;
    logic [mem_line_bits-1:0] mem_data_in;
    logic                     mem_ready;

    logic [addr_bits-1:0] tbl_addr [$];
    logic                 tbl_hit [$];
    int                   tbl_extra [$];
    logic [addr_bits-1:0] burst_addr [$];
    logic [addr_bits-1:0] rand_addr [$];
    int                   lat_table [$];

    logic                shadow_valid [num_lines];
    logic [tag_bits-1:0] shadow_tag [num_lines];

    logic entries_loaded = 1'b0;
    int   req_rises = 0;
    int   mem_served = 0;
    int   errors = 0;
    int   checks = 0;
    int   tests_run = 0;
    int   tests_failed = 0;

    clk_gen #(
        .period       (clk_period),
        .reset_cycles (16)
    ) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    cache_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .read_en     (read_en),
        .addr        (addr),
        .data_out    (data_out),
        .hit         (hit),
        .rdata_valid (rdata_valid),
        .busy        (busy),
        .mem_addr    (mem_addr),
        .mem_req     (mem_req),
        .mem_data_in (mem_data_in),
        .mem_ready   (mem_ready)
    );

    // every word of main memory holds its own address scrambled by a key.
    function automatic logic [word_bits-1:0] model_word(input logic [addr_bits-1:0] a);
        return a ^ model_key;
    endfunction

    function automatic logic [mem_line_bits-1:0] model_line(
        input logic [mem_addr_bits-1:0] line_addr
    );
        return {model_word(line_addr + 32'd3), model_word(line_addr + 32'd2),
                model_word(line_addr + 32'd1), model_word(line_addr)};
    endfunction

    function automatic logic shadow_hit(input logic [addr_bits-1:0] a);
        logic [index_bits-1:0] idx;
        logic [tag_bits-1:0]   tg;
        idx = a[offset_bits +: index_bits];
        tg  = a[addr_bits-1 -: tag_bits];
        return shadow_valid[idx] && (shadow_tag[idx] == tg);
    endfunction

    always @(posedge mem_req) begin
        req_rises++;
    end

    // memory answers a held request after a random number of cycles.
    initial begin
        mem_ready   = 1'b0;
        mem_data_in = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                repeat (lat_table[mem_served % lat_table.size()]) @(negedge clk);
                mem_data_in = model_line(mem_addr);
                mem_ready   = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
                mem_served++;
            end
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string label, input logic [addr_bits-1:0] a,
                               input int fails_before);
        tests_run++;
        if (errors != fails_before) begin
            tests_failed++;
        end
        $display("test %0d %s addr=%h %s", tests_run, label, a,
                 (errors == fails_before) ? "ok" : "failed");
    endtask

    task automatic add_entry(input logic [addr_bits-1:0] a, input logic h, input int extra);
        tbl_addr.push_back(a);
        tbl_hit.push_back(h);
        tbl_extra.push_back(extra);
    endtask

    task automatic load_table();
        add_entry(32'h0000_0104, 1'b0, 0);
        add_entry(32'h0000_0104, 1'b1, 0);
        add_entry(32'h0000_0105, 1'b1, 0);
        add_entry(32'h0000_0107, 1'b1, 0);
        // same index as 0x104 with another tag, so the two lines evict each other.
        add_entry(32'h0000_0904, 1'b0, 0);
        add_entry(32'h0000_0106, 1'b0, 0);
        add_entry(32'h0000_0906, 1'b0, 0);
        add_entry(32'h0000_0905, 1'b1, 0);
        add_entry(32'h1234_5678, 1'b0, 3);
        add_entry(32'h1234_567B, 1'b1, 0);
        add_entry(32'h0000_0000, 1'b0, 4);
        add_entry(32'hFFFF_FFFF, 1'b0, 2);
        add_entry(32'hFFFF_FFFC, 1'b1, 0);
        burst_addr.push_back(32'h0000_0905);
        burst_addr.push_back(32'h1234_5679);
        burst_addr.push_back(32'h0000_0002);
        burst_addr.push_back(32'hFFFF_FFFD);
        burst_addr.push_back(32'h0000_0907);
        burst_addr.push_back(32'h1234_567A);
    endtask

    // issues one request at a falling edge and waits for its response.
    task automatic run_request(input logic [addr_bits-1:0] req_addr, input logic exp_hit,
                               input int extra, input string label);
        int                    cycles;
        int                    extras_left;
        int                    reqs_before;
        int                    fails_before;
        logic                  got_resp;
        logic [index_bits-1:0] idx;
        fails_before = errors;
        reqs_before  = req_rises;
        extras_left  = extra;
        cycles       = 0;
        got_resp     = 1'b0;
        read_en      = 1'b1;
        addr         = req_addr;
        while (!got_resp && cycles < resp_timeout) begin
            @(negedge clk);
            cycles++;
            read_en = 1'b0;
            if (busy && extras_left > 0) begin
                read_en = 1'b1;
                addr    = ~req_addr;
                extras_left--;
            end
            if (mem_req) begin
                check_equal("mem_addr", mem_addr, {req_addr[addr_bits-1:2], 2'b00});
            end
            got_resp = rdata_valid;
        end
        assert (got_resp) else begin
            $display("no response for address %h within %0d cycles", req_addr, resp_timeout);
            errors++;
        end
        if (got_resp) begin
            check_equal("hit", 32'(hit), 32'(exp_hit));
            check_equal("data_out", data_out, model_word(req_addr));
            check_equal("busy", 32'(busy), 32'd0);
            if (exp_hit) begin
                check_equal("rdata_valid latency", 32'(cycles - 1), 32'd2);
            end else begin
                assert (extras_left == 0) else begin
                    $display("busy ended before all %0d extra strobes for %h were sent",
                             extra, req_addr);
                    errors++;
                end
            end
        end
        @(negedge clk);
        check_equal("rdata_valid", 32'(rdata_valid), 32'd0);
        check_equal("mem_req count", 32'(req_rises - reqs_before), exp_hit ? 32'd0 : 32'd1);
        idx = req_addr[offset_bits +: index_bits];
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = req_addr[addr_bits-1 -: tag_bits];
        report_test(label, req_addr, fails_before);
    endtask

    // strobes on consecutive cycles; each response must follow two cycles later.
    task automatic run_burst();
        int   j;
        int   fails_before;
        int   reqs_before;
        logic exp_valid;
        fails_before = errors;
        reqs_before  = req_rises;
        for (int c = 0; c < burst_addr.size() + 3; c++) begin
            if (c < burst_addr.size()) begin
                read_en = 1'b1;
                addr    = burst_addr[c];
            end else begin
                read_en = 1'b0;
            end
            @(negedge clk);
            j = c - 2;
            exp_valid = (j >= 0) && (j < burst_addr.size());
            check_equal("rdata_valid", 32'(rdata_valid), 32'(exp_valid));
            if (exp_valid && rdata_valid) begin
                check_equal("hit", 32'(hit), 32'd1);
                check_equal("data_out", data_out, model_word(burst_addr[j]));
            end
        end
        check_equal("mem_req count", 32'(req_rises - reqs_before), 32'd0);
        report_test("burst", burst_addr[0], fails_before);
    endtask

    initial begin
        logic [31:0] r;
        read_en = 1'b0;
        addr    = '0;
        void'($urandom(rand_seed));
        for (int i = 0; i < 128; i++) begin
            lat_table.push_back(int'($urandom_range(8, 1)));
        end
        // two tags over eight indices give a mix of hits and evictions.
        for (int i = 0; i < rand_len; i++) begin
            r = $urandom;
            rand_addr.push_back({20'h00D2A, r[0], 6'b000000, r[3:1], r[5:4]});
        end
        load_table();
        shadow_valid   = '{default: 1'b0};
        entries_loaded = 1'b1;
        wait (rst === 1'b1);
        @(negedge clk);
        for (int i = 0; i < tbl_addr.size(); i++) begin
            run_request(tbl_addr[i], tbl_hit[i], tbl_extra[i], "table");
        end
        run_burst();
        for (int i = 0; i < rand_addr.size(); i++) begin
            run_request(rand_addr[i], shadow_hit(rand_addr[i]), i % 3, "random");
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // a worst-case miss takes about fifteen cycles, which the margin covers.
    initial begin
        int     entries;
        longint limit_time;
        wait (entries_loaded);
        entries    = tbl_addr.size() + burst_addr.size() + rand_addr.size();
        limit_time = longint'(entries * (8 + 4) * clk_period + (entries * 8 + 200) * clk_period);
        #(limit_time);
        $display("watchdog expired at %0t before all tests finished", $time);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* filelist.f */
common/cache_pkg.sv
common/mem_pkg.sv
hw/addr_parser.sv
cache_core/line_store.sv
cache_core/miss_controller.sv
hw/word_select.sv
hw/cache_top.sv
verification/clk_gen.sv
verification/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log.

verilator --binary --timing --assert --top-module cache_tb -f filelist.f \
    -o cache_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

grep -q "^=== PASS ===$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
